// ==== dv/core_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module core_checker (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    run_i,
    input  rv_types_pkg::word_t     pc_i,
    input  logic                    wb_valid_i,
    input  rv_types_pkg::reg_addr_t wb_rd_i,
    input  rv_types_pkg::word_t     wb_data_i,
    input  logic                    st_valid_i
);

    // Fetch is always on a word boundary
    pc_aligned_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pc_i[1:0] == 2'b00)
        else $error("pc_o is not word aligned");

    pc_parked_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !run_i |=> pc_i == '0)  // PC returns to zero one edge after run drops
        else $error("pc_o left zero while run_i was low");

    no_idle_store_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !run_i |-> !st_valid_i)
        else $error("store reported while run_i was low");

    x0_zero_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wb_valid_i && wb_rd_i == '0) |-> wb_data_i == '0)
        else $error("write to x0 reported non-zero data");

endmodule

bind core_top core_checker i_core_checker (
    .clk_i      ( clk_i ),
    .rst_n_i    ( rst_n_i ),
    .run_i      ( run_i ),
    .pc_i       ( pc_o ),
    .wb_valid_i ( wb_valid_o ),
    .wb_rd_i    ( wb_rd_o ),
    .wb_data_i  ( wb_data_o ),
    .st_valid_i ( st_valid_o )
);

`default_nettype wire

// ==== dv/core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module core_tb;

    typedef rv_types_pkg::word_t     word_t;
    typedef rv_types_pkg::reg_addr_t reg_addr_t;

    localparam int         CLK_PERIOD = 20;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // One program word and what it should do when it retires
    typedef struct packed {
        word_t     instr;
        logic      retires;   // Reached by the program flow
        logic      wb;
        reg_addr_t rd;
        word_t     wb_data;
        logic      st;
        word_t     st_addr;
        word_t     st_data;
    } row_t;

    logic                     clk;
    logic                     rst_n;
    logic                     run;
    logic                     imem_we;
    rv_types_pkg::imem_addr_t imem_addr;
    word_t                    imem_wdata;
    logic                     wb_valid;
    reg_addr_t                wb_rd;
    word_t                    wb_data;
    word_t                    pc;
    logic                     st_valid;
    word_t                    st_addr;
    word_t                    st_data;

    row_t rows_q[$];
    int   error_cnt     = 0;
    int   check_cnt     = 0;
    int   cycle_cnt     = 0;
    int   timeout_limit = 0;

    core_top i_dut (
        .clk_i        ( clk ),
        .rst_n_i      ( rst_n ),
        .run_i        ( run ),
        .imem_we_i    ( imem_we ),
        .imem_addr_i  ( imem_addr ),
        .imem_wdata_i ( imem_wdata ),
        .wb_valid_o   ( wb_valid ),
        .wb_rd_o      ( wb_rd ),
        .wb_data_o    ( wb_data ),
        .pc_o         ( pc ),
        .st_valid_o   ( st_valid ),
        .st_addr_o    ( st_addr ),
        .st_data_o    ( st_data )
    );

    // RV32I instruction formats
    function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3,
                                     input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic word_t j_type(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic wb_row(input word_t instr, input reg_addr_t rd, input word_t data);
        rows_q.push_back(row_t'{instr, 1'b1, 1'b1, rd, data, 1'b0, 32'h0, 32'h0});
    endtask

    task automatic store_row(input word_t instr, input word_t addr, input word_t data);
        rows_q.push_back(row_t'{instr, 1'b1, 1'b0, 5'd0, 32'h0, 1'b1, addr, data});
    endtask

    task automatic quiet_row(input word_t instr);
        rows_q.push_back(row_t'{instr, 1'b1, 1'b0, 5'd0, 32'h0, 1'b0, 32'h0, 32'h0});
    endtask

    task automatic skip_row(input word_t instr);
        rows_q.push_back(row_t'{instr, 1'b0, 1'b0, 5'd0, 32'h0, 1'b0, 32'h0, 32'h0});
    endtask

    // Row index times four is the instruction address
    task automatic build_program();
        word_t filler;
        filler = i_type(12'hFFF, 0, 3'b000, 21, OPC_OP_IMM);  // Visible if executed
        wb_row(i_type(12'd5, 0, 3'b000, 1, OPC_OP_IMM), 1, 32'h0000_0005);
        wb_row(i_type(12'hFFD, 0, 3'b000, 2, OPC_OP_IMM), 2, 32'hFFFF_FFFD);
        wb_row(r_type(7'h00, 2, 1, 3'b000, 3), 3, 32'h0000_0002);       // add
        wb_row(r_type(7'h20, 1, 0, 3'b000, 4), 4, 32'hFFFF_FFFB);       // 0 - 5
        wb_row(i_type(12'h401, 2, 3'b101, 5, OPC_OP_IMM), 5, 32'hFFFF_FFFE);  // srai
        wb_row(r_type(7'h00, 1, 2, 3'b101, 6), 6, 32'h07FF_FFFF);       // srl
        wb_row(r_type(7'h00, 1, 2, 3'b010, 7), 7, 32'h0000_0001);       // slt -3 < 5
        wb_row(r_type(7'h00, 1, 2, 3'b011, 8), 8, 32'h0000_0000);       // sltu
        wb_row(r_type(7'h00, 2, 1, 3'b100, 9), 9, 32'hFFFF_FFF8);       // xor
        wb_row(r_type(7'h00, 2, 1, 3'b110, 10), 10, 32'hFFFF_FFFD);     // or
        wb_row(r_type(7'h00, 1, 1, 3'b001, 11), 11, 32'h0000_00A0);     // sll
        wb_row(i_type(12'h0F0, 2, 3'b111, 12, OPC_OP_IMM), 12, 32'h0000_00F0);
        wb_row(u_type(20'h12345, 13), 13, 32'h1234_5000);
        wb_row(i_type(12'h678, 13, 3'b000, 13, OPC_OP_IMM), 13, 32'h1234_5678);
        wb_row(i_type(12'd7, 1, 3'b000, 0, OPC_OP_IMM), 0, 32'h0000_0000);  // To x0
        wb_row(r_type(7'h00, 1, 0, 3'b000, 14), 14, 32'h0000_0005);     // x0 reads 0
        wb_row(i_type(12'h100, 0, 3'b000, 15, OPC_OP_IMM), 15, 32'h0000_0100);
        store_row(s_type(12'd0, 13, 15, 3'b010), 32'h0000_0100, 32'h1234_5678);
        store_row(s_type(12'd2, 2, 15, 3'b001), 32'h0000_0102, 32'hFFFF_FFFD);
        store_row(s_type(12'd1, 11, 15, 3'b000), 32'h0000_0101, 32'h0000_00A0);
        wb_row(i_type(12'd0, 15, 3'b010, 16, OPC_LOAD), 16, 32'hFFFD_A078);  // Merged
        wb_row(i_type(12'd2, 15, 3'b001, 17, OPC_LOAD), 17, 32'hFFFF_FFFD);
        wb_row(i_type(12'd2, 15, 3'b101, 18, OPC_LOAD), 18, 32'h0000_FFFD);
        wb_row(i_type(12'd1, 15, 3'b000, 19, OPC_LOAD), 19, 32'hFFFF_FFA0);
        wb_row(i_type(12'd1, 15, 3'b100, 20, OPC_LOAD), 20, 32'h0000_00A0);
        quiet_row(b_type(13'd8, 14, 1, 3'b000));  // beq taken
        skip_row(filler);
        quiet_row(b_type(13'd8, 14, 1, 3'b001));  // bne not taken
        quiet_row(b_type(13'd8, 2, 1, 3'b000));   // beq not taken
        quiet_row(b_type(13'd8, 2, 1, 3'b001));   // bne taken
        skip_row(filler);
        wb_row(j_type(21'd12, 22), 22, 32'h0000_0080);
        skip_row(filler);
        skip_row(filler);
        wb_row(i_type(12'h0A1, 0, 3'b000, 24, OPC_JALR), 24, 32'h0000_008C);  // To 0xA0
        repeat (5) begin
            skip_row(filler);
        end
        quiet_row(32'h0000_000B);  // Unknown opcode
        wb_row(i_type(12'd1, 22, 3'b000, 25, OPC_OP_IMM), 25, 32'h0000_0081);
        wb_row(j_type(21'd0, 0), 0, 32'h0000_0000);  // Parks on itself
    endtask

    task automatic report_value(input string name, input word_t exp, input word_t got);
        error_cnt++;
        $display("error: %s expected %h got %h at pc %h", name, exp, got, pc);
    endtask

    task automatic check_idle();
        check_cnt++;
        if (pc !== 32'h0) begin
            report_value("pc_o", 32'h0, pc);
        end
        if (wb_valid !== 1'b0) begin
            report_value("wb_valid_o", 32'h0, wb_valid);
        end
        if (st_valid !== 1'b0) begin
            report_value("st_valid_o", 32'h0, st_valid);
        end
    endtask

    task automatic check_row(input int idx);
        row_t r;
        r = rows_q[idx];
        check_cnt++;
        if (pc !== word_t'(idx * 4)) begin
            report_value("pc_o", word_t'(idx * 4), pc);
        end
        if (wb_valid !== r.wb) begin
            report_value("wb_valid_o", r.wb, wb_valid);
        end
        if (r.wb && wb_rd !== r.rd) begin
            report_value("wb_rd_o", r.rd, wb_rd);
        end
        if (r.wb && wb_data !== r.wb_data) begin
            report_value("wb_data_o", r.wb_data, wb_data);
        end
        if (st_valid !== r.st) begin
            report_value("st_valid_o", r.st, st_valid);
        end
        if (r.st && st_addr !== r.st_addr) begin
            report_value("st_addr_o", r.st_addr, st_addr);
        end
        if (r.st && st_data !== r.st_data) begin
            report_value("st_data_o", r.st_data, st_data);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
            $display("timeout: program did not finish within %0d cycles", timeout_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        int retire_cnt;
        rst_n      = 1'b0;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        build_program();
        retire_cnt = 0;
        foreach (rows_q[i]) begin
            if (rows_q[i].retires) begin
                retire_cnt++;
            end
        end
        timeout_limit = rows_q.size() + 2 * retire_cnt + 20;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // Load with the core parked at zero
        for (int i = 0; i < rows_q.size(); i++) begin
            @(negedge clk);
            imem_we    = 1'b1;
            imem_addr  = rv_types_pkg::imem_addr_t'(i);
            imem_wdata = rows_q[i].instr;
            #(CLK_PERIOD / 4);
            check_idle();
        end
        @(negedge clk);
        imem_we = 1'b0;
        #(CLK_PERIOD / 4);
        check_idle();

        @(negedge clk);
        run = 1'b1;
        foreach (rows_q[i]) begin
            if (rows_q[i].retires) begin
                #(CLK_PERIOD / 4);  // Trace has settled by mid low phase
                check_row(i);
                @(negedge clk);
            end
        end

        $display("checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+source
source/rv_types_pkg.sv
source/rv_ctrl_pkg.sv
source/instr_memory.sv
source/decoder.sv
source/reg_file.sv
source/alu.sv
source/alu_top.sv
source/pc_unit.sv
source/data_memory.sv
source/core_top.sv
dv/core_checker.sv
dv/core_tb.sv

// ==== source/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  rv_types_pkg::word_t   a_i,
    input  rv_types_pkg::word_t   b_i,
    input  rv_types_pkg::alu_op_e op_i,
    output rv_types_pkg::word_t   result_o,
    output logic                  eq_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];
    assign eq_o  = (a_i == b_i);  // Branch compare

    always_comb begin
        case (op_i)
            rv_types_pkg::ALU_ADD:    result_o = a_i + b_i;
            rv_types_pkg::ALU_SUB:    result_o = a_i - b_i;
            rv_types_pkg::ALU_AND:    result_o = a_i & b_i;
            rv_types_pkg::ALU_OR:     result_o = a_i | b_i;
            rv_types_pkg::ALU_XOR:    result_o = a_i ^ b_i;
            rv_types_pkg::ALU_SLL:    result_o = a_i << shamt;
            rv_types_pkg::ALU_SRL:    result_o = a_i >> shamt;
            rv_types_pkg::ALU_SRA:    result_o = $signed(a_i) >>> shamt;
            rv_types_pkg::ALU_SLT:    result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            rv_types_pkg::ALU_SLTU:   result_o = {31'b0, a_i < b_i};
            rv_types_pkg::ALU_PASS_B: result_o = b_i;
            default:                  result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/alu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    run_i,
    input  rv_ctrl_pkg::ctrl_t      ctrl_i,
    input  rv_types_pkg::reg_addr_t rs1_i,
    input  rv_types_pkg::reg_addr_t rs2_i,
    input  rv_types_pkg::reg_addr_t rd_i,
    input  rv_types_pkg::word_t     imm_i,
    input  rv_types_pkg::word_t     mem_rdata_i,
    input  rv_types_pkg::word_t     pc_plus4_i,
    output rv_types_pkg::word_t     alu_out_o,
    output rv_types_pkg::word_t     rs2_val_o,
    output rv_types_pkg::word_t     wb_data_o,
    output logic                    eq_o
);

    rv_types_pkg::word_t rs1_val;
    rv_types_pkg::word_t alu_b;
    logic                reg_we;

    assign reg_we = run_i & ctrl_i.reg_write;  // No writes while loading
    assign alu_b  = ctrl_i.alu_src_imm ? imm_i : rs2_val_o;

    always_comb begin
        case (ctrl_i.wb_src)
            rv_ctrl_pkg::WB_MEM: wb_data_o = mem_rdata_i;
            rv_ctrl_pkg::WB_PC4: wb_data_o = pc_plus4_i;
            default:             wb_data_o = alu_out_o;
        endcase
    end

    reg_file i_reg_file (
        .clk_i     ( clk_i ),
        .rst_n_i   ( rst_n_i ),
        .we_i      ( reg_we ),
        .rs1_i     ( rs1_i ),
        .rs2_i     ( rs2_i ),
        .rd_i      ( rd_i ),
        .wdata_i   ( wb_data_o ),
        .rs1_val_o ( rs1_val ),
        .rs2_val_o ( rs2_val_o )
    );

    alu i_alu (
        .a_i      ( rs1_val ),
        .b_i      ( alu_b ),
        .op_i     ( ctrl_i.alu_op ),
        .result_o ( alu_out_o ),
        .eq_o     ( eq_o )
    );

endmodule

`default_nettype wire

// ==== source/core_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module core_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     run_i,
    input  logic                     imem_we_i,
    input  rv_types_pkg::imem_addr_t imem_addr_i,
    input  rv_types_pkg::word_t      imem_wdata_i,
    output logic                     wb_valid_o,
    output rv_types_pkg::reg_addr_t  wb_rd_o,
    output rv_types_pkg::word_t      wb_data_o,
    output rv_types_pkg::word_t      pc_o,
    output logic                     st_valid_o,
    output rv_types_pkg::word_t      st_addr_o,
    output rv_types_pkg::word_t      st_data_o
);

    rv_types_pkg::word_t     instr;
    rv_ctrl_pkg::ctrl_t      ctrl;
    rv_types_pkg::reg_addr_t rs1, rs2, rd;
    rv_types_pkg::word_t     imm;
    rv_types_pkg::word_t     alu_out;
    rv_types_pkg::word_t     rs2_val;
    rv_types_pkg::word_t     wb_data;
    rv_types_pkg::word_t     mem_rdata;
    rv_types_pkg::word_t     pc_plus4;
    logic                    eq;
    logic                    dmem_we;

    assign dmem_we    = run_i & ctrl.mem_write;      // Store only while running
    assign wb_valid_o = run_i & ctrl.reg_write;
    assign wb_rd_o    = rd;
    assign wb_data_o  = (rd == '0) ? '0 : wb_data;   // x0 keeps reading zero
    assign st_valid_o = dmem_we;
    assign st_addr_o  = alu_out;
    assign st_data_o  = rs2_val;

    instr_memory i_instr_memory (
        .clk_i        ( clk_i ),
        .imem_we_i    ( imem_we_i ),
        .imem_addr_i  ( imem_addr_i ),
        .imem_wdata_i ( imem_wdata_i ),
        .pc_i         ( pc_o ),
        .instr_o      ( instr )
    );

    decoder i_decoder (
        .instr_i ( instr ),
        .ctrl_o  ( ctrl ),
        .rs1_o   ( rs1 ),
        .rs2_o   ( rs2 ),
        .rd_o    ( rd ),
        .imm_o   ( imm )
    );

    alu_top i_alu_top (
        .clk_i       ( clk_i ),
        .rst_n_i     ( rst_n_i ),
        .run_i       ( run_i ),
        .ctrl_i      ( ctrl ),
        .rs1_i       ( rs1 ),
        .rs2_i       ( rs2 ),
        .rd_i        ( rd ),
        .imm_i       ( imm ),
        .mem_rdata_i ( mem_rdata ),
        .pc_plus4_i  ( pc_plus4 ),
        .alu_out_o   ( alu_out ),
        .rs2_val_o   ( rs2_val ),
        .wb_data_o   ( wb_data ),
        .eq_o        ( eq )
    );

    pc_unit i_pc_unit (
        .clk_i      ( clk_i ),
        .rst_n_i    ( rst_n_i ),
        .run_i      ( run_i ),
        .ctrl_i     ( ctrl ),
        .eq_i       ( eq ),
        .imm_i      ( imm ),
        .alu_out_i  ( alu_out ),
        .pc_o       ( pc_o ),
        .pc_plus4_o ( pc_plus4 )
    );

    data_memory i_data_memory (
        .clk_i      ( clk_i ),
        .we_i       ( dmem_we ),
        .addr_i     ( alu_out ),
        .wdata_i    ( rs2_val ),
        .size_i     ( ctrl.mem_size ),
        .unsigned_i ( ctrl.mem_unsigned ),
        .rdata_o    ( mem_rdata )
    );

endmodule

`default_nettype wire

// ==== source/data_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_macros.svh"

module data_memory (
    input  logic                   clk_i,
    input  logic                   we_i,
    input  rv_types_pkg::word_t    addr_i,
    input  rv_types_pkg::word_t    wdata_i,
    input  rv_ctrl_pkg::mem_size_e size_i,
    input  logic                   unsigned_i,
    output rv_types_pkg::word_t    rdata_o
);

    logic [3:0][7:0]         mem [2**(`RV_DMEM_AW-2)];  // Byte lanes per word
    logic [`RV_DMEM_AW-3:0]  widx;
    logic [4:0]              lane_sh;
    logic [3:0]              be;
    rv_types_pkg::word_t     wdata_sh;
    rv_types_pkg::word_t     rdata_sh;

    assign widx     = addr_i[`RV_DMEM_AW-1:2];
    assign lane_sh  = {addr_i[1:0], 3'b000};   // Byte offset in bits
    assign wdata_sh = wdata_i << lane_sh;
    assign rdata_sh = mem[widx] >> lane_sh;

    always_comb begin
        case (size_i)
            rv_ctrl_pkg::MEM_BYTE: be = 4'b0001 << addr_i[1:0];
            rv_ctrl_pkg::MEM_HALF: be = 4'b0011 << {addr_i[1], 1'b0};
            default:               be = 4'b1111;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem[widx][b] <= wdata_sh[b*8 +: 8];
                end
            end
        end
    end

    // Sign or zero extension of the addressed bytes
    always_comb begin
        case (size_i)
            rv_ctrl_pkg::MEM_BYTE:
                rdata_o = {{24{~unsigned_i & rdata_sh[7]}}, rdata_sh[7:0]};
            rv_ctrl_pkg::MEM_HALF:
                rdata_o = {{16{~unsigned_i & rdata_sh[15]}}, rdata_sh[15:0]};
            default:
                rdata_o = rdata_sh;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module decoder (
    input  rv_types_pkg::word_t     instr_i,
    output rv_ctrl_pkg::ctrl_t      ctrl_o,
    output rv_types_pkg::reg_addr_t rs1_o,
    output rv_types_pkg::reg_addr_t rs2_o,
    output rv_types_pkg::reg_addr_t rd_o,
    output rv_types_pkg::word_t     imm_o
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;    // funct7 bit 5 selects sub and sra

    // Shared funct3 mapping of register and immediate ALU ops
    function automatic rv_types_pkg::alu_op_e arith_op(input logic [2:0] f3,
                                                       input logic       alt_i);
        case (f3)
            3'b000:  return alt_i ? rv_types_pkg::ALU_SUB : rv_types_pkg::ALU_ADD;
            3'b001:  return rv_types_pkg::ALU_SLL;
            3'b010:  return rv_types_pkg::ALU_SLT;
            3'b011:  return rv_types_pkg::ALU_SLTU;
            3'b100:  return rv_types_pkg::ALU_XOR;
            3'b101:  return alt_i ? rv_types_pkg::ALU_SRA : rv_types_pkg::ALU_SRL;
            3'b110:  return rv_types_pkg::ALU_OR;
            default: return rv_types_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign alt    = instr_i[30];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];
    assign rd_o   = instr_i[11:7];

    always_comb begin
        ctrl_o          = '0;                      // Unknown ops retire as no-op
        ctrl_o.alu_op   = rv_types_pkg::ALU_ADD;
        ctrl_o.wb_src   = rv_ctrl_pkg::WB_ALU;
        ctrl_o.mem_size = rv_ctrl_pkg::MEM_WORD;
        ctrl_o.jump     = rv_ctrl_pkg::PC_SEQ;
        imm_o           = {{20{instr_i[31]}}, instr_i[31:20]};  // I-type
        case (opcode)
            OPC_OP: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_op    = arith_op(funct3, alt);
            end
            OPC_OP_IMM: begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.alu_op      = arith_op(funct3, alt & (funct3 == 3'b101));
            end
            OPC_LUI: begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.alu_op      = rv_types_pkg::ALU_PASS_B;
                imm_o              = {instr_i[31:12], 12'b0};
            end
            OPC_LOAD: begin
                ctrl_o.reg_write    = 1'b1;
                ctrl_o.alu_src_imm  = 1'b1;
                ctrl_o.wb_src       = rv_ctrl_pkg::WB_MEM;
                ctrl_o.mem_size     = rv_ctrl_pkg::mem_size_e'(funct3[1:0]);
                ctrl_o.mem_unsigned = funct3[2];
            end
            OPC_STORE: begin
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.mem_write   = 1'b1;
                ctrl_o.mem_size    = rv_ctrl_pkg::mem_size_e'(funct3[1:0]);
                imm_o              = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            end
            OPC_BRANCH: begin
                ctrl_o.branch    = (funct3[2:1] == 2'b00);  // beq and bne only
                ctrl_o.branch_ne = funct3[0];
                imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            end
            OPC_JAL: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.wb_src    = rv_ctrl_pkg::WB_PC4;
                ctrl_o.jump      = rv_ctrl_pkg::PC_JAL;
                imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            OPC_JALR: begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.wb_src      = rv_ctrl_pkg::WB_PC4;
                ctrl_o.jump        = rv_ctrl_pkg::PC_JALR;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/instr_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_macros.svh"

module instr_memory (
    input  logic                     clk_i,
    input  logic                     imem_we_i,
    input  rv_types_pkg::imem_addr_t imem_addr_i,
    input  rv_types_pkg::word_t      imem_wdata_i,
    input  rv_types_pkg::word_t      pc_i,
    output rv_types_pkg::word_t      instr_o
);

    rv_types_pkg::word_t      mem [2**`RV_IMEM_AW];  // Program store
    rv_types_pkg::imem_addr_t fetch_idx;

    always_ff @(posedge clk_i) begin
        if (imem_we_i) begin
            mem[imem_addr_i] <= imem_wdata_i;
        end
    end

    assign fetch_idx = pc_i[`RV_IMEM_AW+1:2];  // Word index from byte PC
    assign instr_o   = mem[fetch_idx];

endmodule

`default_nettype wire

// ==== source/pc_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module pc_unit (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                run_i,
    input  rv_ctrl_pkg::ctrl_t  ctrl_i,
    input  logic                eq_i,
    input  rv_types_pkg::word_t imm_i,
    input  rv_types_pkg::word_t alu_out_i,
    output rv_types_pkg::word_t pc_o,
    output rv_types_pkg::word_t pc_plus4_o
);

    rv_ctrl_pkg::pc_src_e sel;
    rv_types_pkg::word_t  next_pc;
    logic                 taken;

    assign taken      = ctrl_i.branch & (eq_i ^ ctrl_i.branch_ne);  // bne inverts eq
    assign pc_plus4_o = pc_o + 32'd4;

    always_comb begin
        sel = ctrl_i.jump;
        if (sel == rv_ctrl_pkg::PC_SEQ && taken) begin
            sel = rv_ctrl_pkg::PC_BRANCH;
        end
        case (sel)
            rv_ctrl_pkg::PC_BRANCH,
            rv_ctrl_pkg::PC_JAL:  next_pc = pc_o + imm_i;
            rv_ctrl_pkg::PC_JALR: next_pc = {alu_out_i[31:1], 1'b0};
            default:              next_pc = pc_plus4_o;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o <= '0;
        end else if (!run_i) begin
            pc_o <= '0;  // Parked while the program loads
        end else begin
            pc_o <= next_pc;
        end
    end

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_macros.svh"

module reg_file (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    we_i,
    input  rv_types_pkg::reg_addr_t rs1_i,
    input  rv_types_pkg::reg_addr_t rs2_i,
    input  rv_types_pkg::reg_addr_t rd_i,
    input  rv_types_pkg::word_t     wdata_i,
    output rv_types_pkg::word_t     rs1_val_o,
    output rv_types_pkg::word_t     rs2_val_o
);

    rv_types_pkg::word_t regs [1:2**`RV_REG_ADDR_W-1];  // No storage for x0

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 2**`RV_REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    assign rs1_val_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_val_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// ==== source/rv_ctrl_pkg.sv ====
`default_nettype none

package rv_ctrl_pkg;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,  // Same code as funct3[1:0]
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_size_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4             // Link value of jal and jalr
    } wb_src_e;

    typedef enum logic [1:0] {
        PC_SEQ,
        PC_BRANCH,
        PC_JAL,
        PC_JALR
    } pc_src_e;

    typedef struct packed {
        logic                  reg_write;
        logic                  alu_src_imm;   // Immediate as second operand
        rv_types_pkg::alu_op_e alu_op;
        wb_src_e               wb_src;
        logic                  mem_write;
        mem_size_e             mem_size;
        logic                  mem_unsigned;  // lbu and lhu
        logic                  branch;
        logic                  branch_ne;     // bne rather than beq
        pc_src_e               jump;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== source/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

`define RV_XLEN        32   // Data and instruction width
`define RV_REG_ADDR_W  5    // Register index width
`define RV_IMEM_AW     8    // 256 instruction words
`define RV_DMEM_AW     10   // 1 KiB of data bytes

`endif

// ==== source/rv_types_pkg.sv ====
`default_nettype none

`include "rv_macros.svh"

package rv_types_pkg;

    typedef logic [`RV_XLEN-1:0]       word_t;       // Data, address or instruction
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`RV_IMEM_AW-1:0]    imem_addr_t;  // Instruction word index

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B     // lui
    } alu_op_e;

endpackage

`default_nettype wire
